/* hw/bus_pkg.sv */
// --------------------------------------------------------------------------
// Shared definitions of the memory-side interconnect: data widths, device
// codes, mailbox commands, load and store size codes, request and tag
// structs and the boot phase enum
// --------------------------------------------------------------------------
package bus_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] line_t;
    typedef logic [3:0]   dev_t;
    typedef logic [2:0]   funct3_t;
    typedef logic [27:0]  offset_t;

    // Device code in address bits 31..28
    localparam dev_t DEV_DRAM_LO = 4'h0;
    localparam dev_t DEV_VIRTIO  = 4'h4;
    localparam dev_t DEV_PLIC    = 4'h5;
    localparam dev_t DEV_CLINT   = 4'h6;
    localparam dev_t DEV_DRAM    = 4'h8;

    // Framebuffer sub-index in bits 27..24 of the VirtIO window
    localparam logic [3:0] VIRT_FB = 4'h5;

    // DRAM is 128 MiB, so only the low 27 address bits reach it
    localparam addr_t DRAM_ADDR_MASK = 32'h07ff_ffff;

    // To-host mailbox
    localparam addr_t       TOHOST_ADDR    = 32'h4000_8000;
    localparam logic [15:0] CMD_PRINT_CHAR = 16'h0101;
    localparam logic [15:0] CMD_POWER_OFF  = 16'h0002;

    // Load and store size codes, bit 2 marks an unsigned load
    localparam funct3_t FUNCT3_LB  = 3'b000;
    localparam funct3_t FUNCT3_LH  = 3'b001;
    localparam funct3_t FUNCT3_LW  = 3'b010;
    localparam funct3_t FUNCT3_LBU = 3'b100;
    localparam funct3_t FUNCT3_LHU = 3'b101;
    localparam funct3_t FUNCT3_SW  = 3'b010;

    // CPU data request
    typedef struct packed {
        addr_t   addr;
        word_t   wdata;
        funct3_t funct3;
        logic    we;
        logic    re;
    } cpu_req_t;

    // Request on the DRAM port
    typedef struct packed {
        addr_t   addr;
        word_t   wdata;
        funct3_t funct3;
        logic    we;
        logic    re;
    } dram_req_t;

    // Write from the SD card loader
    typedef struct packed {
        word_t data;
        logic  we;
    } loader_wr_t;

    // What the second stage needs to know about last cycle's request
    typedef struct packed {
        dev_t       dev;
        logic [3:0] virt;
        logic [3:0] byte_off;
        funct3_t    funct3;
        logic       is_dram;
    } resp_tag_t;

    typedef enum logic [1:0] {
        BOOT_RESET,
        BOOT_LOAD_BBL,
        BOOT_LOAD_DTB,
        BOOT_DONE
    } boot_phase_e;

endpackage

/* hw/boot_loader_seq.sv */
// --------------------------------------------------------------------------
// Boot phase FSM: kernel image load, device tree load, then done
// Loader address counter for both images
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module boot_loader_seq #(
    parameter int unsigned BBL_SIZE  = 32'h0040_0000,
    parameter int unsigned DTB_START = 32'h0080_0000,
    parameter int unsigned DTB_SIZE  = 32'h0000_2000
) (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 loader_we,
    output bus_pkg::boot_phase_e phase,
    output bus_pkg::addr_t       load_addr,
    output logic                 init_start,
    output logic                 init_done
);

    // Word address of the last write of each image
    // BBL_SIZE counts the device tree as well, which goes elsewhere
    localparam bus_pkg::addr_t BBL_LAST = bus_pkg::addr_t'(BBL_SIZE - DTB_SIZE - 4);
    localparam bus_pkg::addr_t DTB_LAST = bus_pkg::addr_t'(DTB_START + DTB_SIZE - 4);

    always_ff @(posedge CLK) begin
        if (reset) begin
            phase      <= bus_pkg::BOOT_RESET;
            load_addr  <= '0;
            init_start <= 1'b0;
        end else begin
            case (phase)
                bus_pkg::BOOT_RESET: begin
                    phase <= bus_pkg::BOOT_LOAD_BBL;
                end
                bus_pkg::BOOT_LOAD_BBL: begin
                    if (loader_we) begin
                        init_start <= 1'b1;
                        if (load_addr == BBL_LAST) begin
                            // Device tree has its own base
                            phase     <= bus_pkg::BOOT_LOAD_DTB;
                            load_addr <= bus_pkg::addr_t'(DTB_START);
                        end else begin
                            load_addr <= load_addr + 32'd4;
                        end
                    end
                end
                bus_pkg::BOOT_LOAD_DTB: begin
                    if (loader_we) begin
                        load_addr <= load_addr + 32'd4;
                        if (load_addr == DTB_LAST) begin
                            phase <= bus_pkg::BOOT_DONE;
                        end
                    end
                end
                bus_pkg::BOOT_DONE: begin
                    phase <= bus_pkg::BOOT_DONE;
                end
                default: begin
                    phase <= bus_pkg::BOOT_RESET;
                end
            endcase
        end
    end

    assign init_done = (phase == bus_pkg::BOOT_DONE);

endmodule

/* hw/req_decode.sv */
// --------------------------------------------------------------------------
// First pipeline stage: address decode, DRAM port mux between loader
// and CPU, PLIC / CLINT / framebuffer strobes, registered response tag
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module req_decode (
    input  logic                 CLK,
    input  logic                 reset,
    input  bus_pkg::cpu_req_t    cpu,
    input  bus_pkg::loader_wr_t  loader,
    input  bus_pkg::boot_phase_e phase,
    input  bus_pkg::addr_t       load_addr,
    input  logic                 dram_busy,
    output bus_pkg::dram_req_t   dram,
    output logic                 plic_we,
    output logic                 plic_re,
    output logic                 clint_we,
    output logic                 fb_we,
    output bus_pkg::word_t       dev_wdata,
    output bus_pkg::offset_t     offset,
    output bus_pkg::resp_tag_t   tag,
    output logic                 busy
);

    bus_pkg::dev_t      dev;
    logic [3:0]         virt;
    logic               dram_sel;
    logic               loading;
    logic               boot_done;
    bus_pkg::resp_tag_t tag_next;

    assign dev  = cpu.addr[31:28];
    assign virt = cpu.addr[27:24];

    // Two windows alias onto the same DRAM
    assign dram_sel = (dev == bus_pkg::DEV_DRAM) || (dev == bus_pkg::DEV_DRAM_LO);

    assign loading   = (phase == bus_pkg::BOOT_LOAD_BBL) ||
                       (phase == bus_pkg::BOOT_LOAD_DTB);
    assign boot_done = (phase == bus_pkg::BOOT_DONE);

    // DRAM port
    always_comb begin
        if (loading) begin
            // Loader owns the port, so dram_busy does not hold it off
            dram.addr   = load_addr;
            dram.wdata  = loader.data;
            dram.funct3 = bus_pkg::FUNCT3_SW;
            dram.we     = loader.we;
            dram.re     = 1'b0;
        end else begin
            dram.addr   = cpu.addr & bus_pkg::DRAM_ADDR_MASK;
            dram.wdata  = cpu.wdata;
            dram.funct3 = cpu.funct3;
            // CPU request is dropped while DRAM is busy; it sees busy and retries
            dram.we     = boot_done && dram_sel && cpu.we && !dram_busy;
            dram.re     = boot_done && dram_sel && cpu.re && !dram_busy;
        end
    end

    // Device strobes, same cycle as the request
    assign plic_we  = boot_done && (dev == bus_pkg::DEV_PLIC) && cpu.we;
    assign plic_re  = boot_done && (dev == bus_pkg::DEV_PLIC) && cpu.re;
    assign clint_we = boot_done && (dev == bus_pkg::DEV_CLINT) && cpu.we;
    assign fb_we    = boot_done && (dev == bus_pkg::DEV_VIRTIO) &&
                      (virt == bus_pkg::VIRT_FB) && cpu.we;

    assign dev_wdata = cpu.wdata;
    assign offset    = cpu.addr[27:0];

    assign busy = dram_busy || !boot_done;

    // Tag for the response stage, one request per cycle
    always_comb begin
        tag_next.dev      = dev;
        tag_next.virt     = virt;
        tag_next.byte_off = cpu.addr[3:0];
        tag_next.funct3   = cpu.funct3;
        tag_next.is_dram  = dram_sel;
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            tag <= '0;
        end else begin
            tag <= tag_next;
        end
    end

endmodule

/* hw/resp_select.sv */
// --------------------------------------------------------------------------
// Second pipeline stage: load extraction from the 128-bit DRAM line
// and read data mux for PLIC, CLINT and framebuffer
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module resp_select (
    input  bus_pkg::resp_tag_t tag,
    input  bus_pkg::line_t     dram_rdata,
    input  bus_pkg::word_t     plic_rdata,
    input  bus_pkg::word_t     clint_rdata,
    input  bus_pkg::word_t     fb_rdata,
    output bus_pkg::line_t     rdata,
    output logic               rdata_is_dram
);

    bus_pkg::line_t shifted;
    bus_pkg::word_t raw;
    bus_pkg::word_t load_word;
    bus_pkg::word_t dev_word;
    logic           narrow;

    // Bring the addressed byte down to bit 0
    assign shifted = dram_rdata >> {tag.byte_off, 3'b000};
    assign raw     = shifted[31:0];

    always_comb begin
        narrow = 1'b1;
        case (tag.funct3)
            bus_pkg::FUNCT3_LB:  load_word = {{24{raw[7]}}, raw[7:0]};
            bus_pkg::FUNCT3_LBU: load_word = {24'h0, raw[7:0]};
            bus_pkg::FUNCT3_LH:  load_word = {{16{raw[15]}}, raw[15:0]};
            bus_pkg::FUNCT3_LHU: load_word = {16'h0, raw[15:0]};
            default: begin
                load_word = raw;
                narrow    = 1'b0;
            end
        endcase
    end

    // Device read data, unmapped devices read zero
    always_comb begin
        case (tag.dev)
            bus_pkg::DEV_PLIC:  dev_word = plic_rdata;
            bus_pkg::DEV_CLINT: dev_word = clint_rdata;
            bus_pkg::DEV_VIRTIO: begin
                if (tag.virt == bus_pkg::VIRT_FB) begin
                    dev_word = fb_rdata;
                end else begin
                    dev_word = '0;
                end
            end
            default:            dev_word = '0;
        endcase
    end

    // Word loads get the raw line, the CPU picks its word itself
    // Narrow loads get the extended value in the low word
    always_comb begin
        if (tag.is_dram) begin
            if (narrow) begin
                rdata = {dram_rdata[127:32], load_word};
            end else begin
                rdata = dram_rdata;
            end
        end else begin
            rdata = {96'h0, dev_word};
        end
    end

    assign rdata_is_dram = tag.is_dram;

endmodule

/* hw/host_mailbox.sv */
// --------------------------------------------------------------------------
// To-host mailbox register
// Print-character pulse and sticky power-off flag
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module host_mailbox (
    input  logic              CLK,
    input  logic              reset,
    input  bus_pkg::cpu_req_t cpu,
    output logic              print_we,
    output logic [7:0]        print_char,
    output logic              finish
);

    bus_pkg::word_t tohost;
    logic           cmd_print;
    logic           cmd_off;

    assign cmd_print = (tohost[31:16] == bus_pkg::CMD_PRINT_CHAR);
    assign cmd_off   = (tohost[31:16] == bus_pkg::CMD_POWER_OFF);

    always_ff @(posedge CLK) begin
        if (reset) begin
            tohost   <= '0;
            print_we <= 1'b0;
            finish   <= 1'b0;
        end else begin
            if (cpu.we && (cpu.addr == bus_pkg::TOHOST_ADDR)) begin
                tohost <= cpu.wdata;
            end else if (cmd_print) begin
                // Character consumed
                tohost <= '0;
            end
            print_we <= cmd_print;
            // Stays set until reset
            if (cmd_off) begin
                finish <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (cmd_print) begin
            print_char <= tohost[7:0];
        end
    end

endmodule

/* hw/bus_interconnect.sv */
// --------------------------------------------------------------------------
// Interconnect top level: boot sequencer, request decode stage,
// response select stage and to-host mailbox
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module bus_interconnect #(
    parameter int unsigned BBL_SIZE  = 32'h0040_0000,
    parameter int unsigned DTB_START = 32'h0080_0000,
    parameter int unsigned DTB_SIZE  = 32'h0000_2000
) (
    input  logic                CLK,
    input  logic                reset,
    input  bus_pkg::cpu_req_t   cpu,
    input  bus_pkg::loader_wr_t loader,
    input  logic                dram_busy,
    input  bus_pkg::line_t      dram_rdata,
    input  bus_pkg::word_t      plic_rdata,
    input  bus_pkg::word_t      clint_rdata,
    input  bus_pkg::word_t      fb_rdata,
    output bus_pkg::dram_req_t  dram,
    output logic                plic_we,
    output logic                plic_re,
    output logic                clint_we,
    output logic                fb_we,
    output bus_pkg::word_t      dev_wdata,
    output bus_pkg::offset_t    offset,
    output bus_pkg::line_t      rdata,
    output logic                rdata_is_dram,
    output logic                print_we,
    output logic [7:0]          print_char,
    output logic                finish,
    output logic                init_start,
    output logic                init_done,
    output logic                busy
);

    bus_pkg::boot_phase_e phase;
    bus_pkg::addr_t       load_addr;
    bus_pkg::resp_tag_t   tag;

    boot_loader_seq #(
        .BBL_SIZE  (BBL_SIZE),
        .DTB_START (DTB_START),
        .DTB_SIZE  (DTB_SIZE)
    ) boot_loader_seq_i (
        .CLK        (CLK),
        .reset      (reset),
        .loader_we  (loader.we),
        .phase      (phase),
        .load_addr  (load_addr),
        .init_start (init_start),
        .init_done  (init_done)
    );

    req_decode req_decode_i (
        .CLK       (CLK),
        .reset     (reset),
        .cpu       (cpu),
        .loader    (loader),
        .phase     (phase),
        .load_addr (load_addr),
        .dram_busy (dram_busy),
        .dram      (dram),
        .plic_we   (plic_we),
        .plic_re   (plic_re),
        .clint_we  (clint_we),
        .fb_we     (fb_we),
        .dev_wdata (dev_wdata),
        .offset    (offset),
        .tag       (tag),
        .busy      (busy)
    );

    // Consumes the tag registered one cycle earlier
    resp_select resp_select_i (
        .tag           (tag),
        .dram_rdata    (dram_rdata),
        .plic_rdata    (plic_rdata),
        .clint_rdata   (clint_rdata),
        .fb_rdata      (fb_rdata),
        .rdata         (rdata),
        .rdata_is_dram (rdata_is_dram)
    );

    host_mailbox host_mailbox_i (
        .CLK        (CLK),
        .reset      (reset),
        .cpu        (cpu),
        .print_we   (print_we),
        .print_char (print_char),
        .finish     (finish)
    );

endmodule

/* sim/bus_interconnect_properties.sv */
// --------------------------------------------------------------------------
// Concurrent assertions on the DRAM port and the mailbox outputs
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module bus_interconnect_properties (
    input logic               CLK,
    input logic               reset,
    input bus_pkg::dram_req_t dram,
    input logic               dram_busy,
    input logic               init_done,
    input logic               print_we,
    input logic               finish
);

    // One direction per cycle on the DRAM port
    property dram_we_re_exclusive;
        @(posedge CLK) disable iff (reset) !(dram.we && dram.re);
    endproperty

    // CPU strobes held off while DRAM is busy
    property dram_idle_when_busy;
        @(posedge CLK) disable iff (reset) (init_done && dram_busy) |-> !(dram.we || dram.re);
    endproperty

    property print_single_cycle;
        @(posedge CLK) disable iff (reset) print_we |=> !print_we;
    endproperty

    // Power-off is sticky
    property finish_sticky;
        @(posedge CLK) disable iff (reset) finish |=> finish;
    endproperty

    assert property (dram_we_re_exclusive) else $error("DRAM write and read in one cycle");
    assert property (dram_idle_when_busy) else $error("DRAM strobe while DRAM busy");
    assert property (print_single_cycle) else $error("print_we longer than one cycle");
    assert property (finish_sticky) else $error("finish fell before reset");

endmodule

/* sim/bus_interconnect_tb.sv */
// --------------------------------------------------------------------------
// Interconnect testbench: clock, reset, DRAM and device models, boot load,
// table of CPU requests with expected responses, mailbox checks, summary
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module bus_interconnect_tb;

    // Fixed line returned by the DRAM model, bytes 0x0f up to 0xf0
    localparam bus_pkg::line_t LINE = 128'hf0e1d2c3_b4a59687_78695a4b_3c2d1e0f;

    typedef struct packed {
        bus_pkg::cpu_req_t cpu;
        logic              stall;
        logic [1:0]        port;    // dram we, re
        logic [3:0]        strobe;  // plic_we, plic_re, clint_we, fb_we
        logic              chk_rd;
        bus_pkg::line_t    exp_rd;
        logic              exp_is_dram;
    } step_t;

    logic                CLK;
    logic                reset;
    logic                dram_busy;
    bus_pkg::cpu_req_t   cpu;
    bus_pkg::loader_wr_t loader;
    bus_pkg::line_t      dram_rdata;
    bus_pkg::word_t      plic_rdata;
    bus_pkg::word_t      clint_rdata;
    bus_pkg::word_t      fb_rdata;
    bus_pkg::dram_req_t  dram;
    logic                plic_we;
    logic                plic_re;
    logic                clint_we;
    logic                fb_we;
    bus_pkg::word_t      dev_wdata;
    bus_pkg::offset_t    offset;
    bus_pkg::line_t      rdata;
    logic                rdata_is_dram;
    logic                print_we;
    logic [7:0]          print_char;
    logic                finish;
    logic                init_start;
    logic                init_done;
    logic                busy;

    step_t            steps[$];
    bus_pkg::funct3_t sizes[5];
    bus_pkg::word_t   ldata;
    integer           seed;
    int               errors;
    int               checks;

    bus_interconnect #(
        .BBL_SIZE  (40),
        .DTB_START (32'h100),
        .DTB_SIZE  (8)
    ) bus_interconnect_i (.*);

    bind bus_interconnect bus_interconnect_properties props_i (
        .CLK       (CLK),
        .reset     (reset),
        .dram      (dram),
        .dram_busy (dram_busy),
        .init_done (init_done),
        .print_we  (print_we),
        .finish    (finish)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // DRAM answers one cycle after a read strobe
    always @(posedge CLK) begin
        dram_rdata <= dram.re ? LINE : '0;
    end

    task check_value(input string name, input bus_pkg::line_t got, input bus_pkg::line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %0h expected %0h", name, got, exp);
        end
    endtask

    // Byte offset shift, then sign or zero extension by size code
    function automatic bus_pkg::line_t load_expect(input int off, input bus_pkg::funct3_t f3);
        bus_pkg::word_t raw;
        bus_pkg::word_t ext;
        for (int k = 0; k < 4; k++) begin
            raw[k*8 +: 8] = (off + k < 16) ? LINE[(off + k) * 8 +: 8] : 8'h00;
        end
        case (f3)
            bus_pkg::FUNCT3_LB:  ext = {{24{raw[7]}}, raw[7:0]};
            bus_pkg::FUNCT3_LBU: ext = {24'h0, raw[7:0]};
            bus_pkg::FUNCT3_LH:  ext = {{16{raw[15]}}, raw[15:0]};
            bus_pkg::FUNCT3_LHU: ext = {16'h0, raw[15:0]};
            default:             return LINE;
        endcase
        return {LINE[127:32], ext};
    endfunction

    function automatic bus_pkg::cpu_req_t make_req(input bus_pkg::addr_t a,
            input bus_pkg::word_t d, input bus_pkg::funct3_t f3, input logic we, input logic re);
        return '{addr: a, wdata: d, funct3: f3, we: we, re: re};
    endfunction

    task add_step(input bus_pkg::cpu_req_t c, input logic stall, input logic [1:0] port,
            input logic [3:0] strobe, input logic chk, input bus_pkg::line_t exp,
            input logic is_dram);
        step_t s;
        s = '{c, stall, port, strobe, chk, exp, is_dram};
        steps.push_back(s);
    endtask

    // Same-cycle outputs of one table row
    task check_step(input step_t s);
        check_value("dram.we", dram.we, s.port[1]);
        check_value("dram.re", dram.re, s.port[0]);
        check_value("plic_we", plic_we, s.strobe[3]);
        check_value("plic_re", plic_re, s.strobe[2]);
        check_value("clint_we", clint_we, s.strobe[1]);
        check_value("fb_we", fb_we, s.strobe[0]);
        check_value("busy", busy, s.stall);
        check_value("dev_wdata", dev_wdata, s.cpu.wdata);
        check_value("offset", offset, s.cpu.addr[27:0]);
        if (s.port != 2'b00) begin
            check_value("dram.addr", dram.addr, s.cpu.addr & 32'h07ff_ffff);
            check_value("dram.wdata", dram.wdata, s.cpu.wdata);
            check_value("dram.funct3", dram.funct3, s.cpu.funct3);
        end
    endtask

    // Waits for init_done, print_we or finish and checks its latency
    task await_signal(input int sel, input int want);
        int    lat;
        logic  seen;
        string name;
        lat  = 0;
        seen = 1'b0;
        name = (sel == 0) ? "init_done" : (sel == 1) ? "print_we" : "finish";
        while (!seen && lat < 8) begin
            @(negedge CLK);
            lat++;
            seen = (sel == 0) ? init_done : (sel == 1) ? print_we : finish;
        end
        if (!seen) begin
            errors++;
            $display("%s did not rise within 8 cycles", name);
        end else begin
            check_value({name, " latency"}, lat, want);
        end
    endtask

    initial begin
        seed        = 32'h7dc7;
        errors      = 0;
        checks      = 0;
        reset       = 1'b1;
        dram_busy   = 1'b0;
        cpu         = '0;
        loader      = '0;
        dram_rdata  = '0;
        plic_rdata  = 32'h1111_1111;
        clint_rdata = 32'h2222_2222;
        fb_rdata    = 32'h3333_3333;
        sizes       = '{bus_pkg::FUNCT3_LB, bus_pkg::FUNCT3_LBU, bus_pkg::FUNCT3_LH,
                        bus_pkg::FUNCT3_LHU, bus_pkg::FUNCT3_LW};
        repeat (2) @(posedge CLK);
        reset <= 1'b0;
        // CPU DRAM request held through the boot load
        cpu   <= make_req(32'h8000_0000, 32'hdead_beef, bus_pkg::FUNCT3_LW, 1'b1, 1'b1);
        @(negedge CLK);
        check_value("dram.we", dram.we, 1'b0);
        check_value("dram.re", dram.re, 1'b0);
        check_value("print_we", print_we, 1'b0);
        check_value("finish", finish, 1'b0);
        check_value("init_start", init_start, 1'b0);
        check_value("init_done", init_done, 1'b0);
        check_value("busy", busy, 1'b1);

        // Boot load, 8 kernel words then 2 device tree words
        for (int i = 0; i < 10; i++) begin
            @(posedge CLK);
            ldata = $random(seed);
            loader <= '{data: ldata, we: 1'b1};
            @(negedge CLK);
            check_value("dram.we", dram.we, 1'b1);
            check_value("dram.re", dram.re, 1'b0);
            check_value("dram.addr", dram.addr, (i < 8) ? i * 4 : 32'h100 + (i - 8) * 4);
            check_value("dram.wdata", dram.wdata, ldata);
            check_value("dram.funct3", dram.funct3, bus_pkg::FUNCT3_SW);
            check_value("init_start", init_start, i > 0);
            check_value("init_done", init_done, 1'b0);
        end
        @(posedge CLK);
        loader <= '0;
        cpu    <= '0;
        await_signal(0, 1);

        // DRAM loads over every byte offset, both DRAM windows
        for (int off = 0; off < 16; off++) begin
            for (int k = 0; k < 5; k++) begin
                add_step(make_req(((off % 2) ? 32'h8000_0040 : 32'h0000_0040) + off, '0,
                         sizes[k], 1'b0, 1'b1), 1'b0, 2'b01, 4'h0, 1'b1,
                         load_expect(off, sizes[k]), 1'b1);
            end
        end
        add_step(make_req(32'h8fff_fffc, 32'hcafe_f00d, bus_pkg::FUNCT3_SW, 1'b1, 1'b0),
                 1'b0, 2'b10, 4'h0, 1'b0, '0, 1'b0);
        // Devices: PLIC, CLINT, framebuffer, then unmapped
        add_step(make_req(32'h5000_0010, 32'ha5a5_0001, bus_pkg::FUNCT3_SW, 1'b1, 1'b0),
                 1'b0, 2'b00, 4'b1000, 1'b0, '0, 1'b0);
        add_step(make_req(32'h5000_0010, '0, bus_pkg::FUNCT3_LW, 1'b0, 1'b1),
                 1'b0, 2'b00, 4'b0100, 1'b1, {96'h0, 32'h1111_1111}, 1'b0);
        add_step(make_req(32'h6000_4000, 32'h5a5a_0002, bus_pkg::FUNCT3_SW, 1'b1, 1'b0),
                 1'b0, 2'b00, 4'b0010, 1'b0, '0, 1'b0);
        add_step(make_req(32'h6000_4000, '0, bus_pkg::FUNCT3_LW, 1'b0, 1'b1),
                 1'b0, 2'b00, 4'b0000, 1'b1, {96'h0, 32'h2222_2222}, 1'b0);
        add_step(make_req(32'h4500_0100, 32'h0f0f_0003, bus_pkg::FUNCT3_SW, 1'b1, 1'b0),
                 1'b0, 2'b00, 4'b0001, 1'b0, '0, 1'b0);
        add_step(make_req(32'h4500_0100, '0, bus_pkg::FUNCT3_LW, 1'b0, 1'b1),
                 1'b0, 2'b00, 4'b0000, 1'b1, {96'h0, 32'h3333_3333}, 1'b0);
        add_step(make_req(32'h4100_0000, 32'h0000_0004, bus_pkg::FUNCT3_SW, 1'b1, 1'b0),
                 1'b0, 2'b00, 4'b0000, 1'b0, '0, 1'b0);
        add_step(make_req(32'h4100_0000, '0, bus_pkg::FUNCT3_LW, 1'b0, 1'b1),
                 1'b0, 2'b00, 4'b0000, 1'b1, '0, 1'b0);
        add_step(make_req(32'h7000_0000, '0, bus_pkg::FUNCT3_LW, 1'b0, 1'b1),
                 1'b0, 2'b00, 4'b0000, 1'b1, '0, 1'b0);
        // Back-pressure, then the retried read
        add_step(make_req(32'h8000_0080, '0, bus_pkg::FUNCT3_LW, 1'b0, 1'b1),
                 1'b1, 2'b00, 4'h0, 1'b0, '0, 1'b0);
        add_step(make_req(32'h8000_0080, 32'h1234_5678, bus_pkg::FUNCT3_SW, 1'b1, 1'b0),
                 1'b1, 2'b00, 4'h0, 1'b0, '0, 1'b0);
        add_step(make_req(32'h8000_0080, '0, bus_pkg::FUNCT3_LW, 1'b0, 1'b1),
                 1'b0, 2'b01, 4'h0, 1'b1, LINE, 1'b1);

        // Read data of each row is checked one cycle after it
        for (int i = 0; i <= steps.size(); i++) begin
            @(posedge CLK);
            if (i < steps.size()) begin
                cpu       <= steps[i].cpu;
                dram_busy <= steps[i].stall;
            end else begin
                cpu       <= '0;
                dram_busy <= 1'b0;
            end
            @(negedge CLK);
            if (i < steps.size()) begin
                check_step(steps[i]);
            end
            if (i > 0 && steps[i - 1].chk_rd) begin
                check_value("rdata", rdata, steps[i - 1].exp_rd);
                check_value("rdata_is_dram", rdata_is_dram, steps[i - 1].exp_is_dram);
            end
        end

        // Mailbox print
        @(posedge CLK);
        cpu <= make_req(bus_pkg::TOHOST_ADDR, {bus_pkg::CMD_PRINT_CHAR, 16'h0041},
                        bus_pkg::FUNCT3_SW, 1'b1, 1'b0);
        @(posedge CLK);
        cpu <= '0;
        await_signal(1, 2);
        check_value("print_char", print_char, 8'h41);
        @(negedge CLK);
        check_value("print_we", print_we, 1'b0);
        check_value("finish", finish, 1'b0);

        // Mailbox power-off
        @(posedge CLK);
        cpu <= make_req(bus_pkg::TOHOST_ADDR, {bus_pkg::CMD_POWER_OFF, 16'h0000},
                        bus_pkg::FUNCT3_SW, 1'b1, 1'b0);
        @(posedge CLK);
        cpu <= '0;
        await_signal(2, 2);
        repeat (4) begin
            @(negedge CLK);
            check_value("finish", finish, 1'b1);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* build.f */
hw/bus_pkg.sv
hw/boot_loader_seq.sv
hw/req_decode.sv
hw/resp_select.sv
hw/host_mailbox.sv
hw/bus_interconnect.sv
sim/bus_interconnect_properties.sv
sim/bus_interconnect_tb.sv

/* Bender.yml */
package:
  name: bus_interconnect

sources:
  - files:
      - hw/bus_pkg.sv
      - hw/boot_loader_seq.sv
      - hw/req_decode.sv
      - hw/resp_select.sv
      - hw/host_mailbox.sv
      - hw/bus_interconnect.sv
  - target: test
    files:
      - sim/bus_interconnect_properties.sv
      - sim/bus_interconnect_tb.sv
